// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP      := tb_frame_split
FILELIST := build.f
PASS_MSG := No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# output goes to the terminal and the exit status comes from the search
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: build.f
source/eth_rx_pkg.sv
source/inet_sum.sv
source/split_ctrl.sv
source/header_capture.sv
source/rx_output.sv
source/frame_split.sv
verification/frame_split_assert.sv
verification/tb_frame_split.sv

// File: source/eth_rx_pkg.sv
package eth_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [31:0] sum_t;         // unfolded ones-complement sum
    typedef logic [15:0] count_t;

    typedef struct packed {
        byte_t data;
        logic  valid;
        logic  last;
    } beat_t;

    typedef enum logic [2:0] {
        IDLE,
        ETH_HEAD,
        IP_HEAD,
        UDP_HEAD,
        UDP_DATA,
        ARP_DATA,
        DISCARD
    } split_state_t;

    typedef struct packed {
        logic   eth_ok;                 // dst mac is ours or broadcast
        logic   is_arp;
        logic   is_ipv4;
        logic   ip_ok;                  // checksum, ver/ihl, dst ip and protocol good
        count_t payload_len;            // udp length minus header
    } hdr_verdict_t;

    localparam mac_t     LOCAL_MAC    = 48'hABCD_1234_5678;
    localparam mac_t     BCAST_MAC    = 48'hFFFF_FFFF_FFFF;
    localparam ip_addr_t LOCAL_IP     = 32'hC0A8_006E;
    localparam word_t    ARP_TYPE     = 16'h0806;
    localparam word_t    IPV4_TYPE    = 16'h0800;
    localparam byte_t    UDP_PROTO    = 8'h11;
    localparam byte_t    IPV4_VER_IHL = 8'h45;
    localparam count_t   ETH_HEAD_LEN = 16'd14;
    localparam count_t   IP_HEAD_LEN  = 16'd20;
    localparam count_t   UDP_HEAD_LEN = 16'd8;

    // two carry folds are enough for any 32-bit running sum
    function automatic word_t fold_sum(input sum_t raw);
        sum_t part;
        part = {16'h0000, raw[31:16]} + {16'h0000, raw[15:0]};
        part = {16'h0000, part[31:16]} + {16'h0000, part[15:0]};
        return part[15:0];
    endfunction

endpackage

// File: source/frame_split.sv
`timescale 1ns/10ps

module frame_split (
    input  logic              logic_clk,
    input  logic              logic_rst,
    input  eth_rx_pkg::beat_t rx_beat_i,
    output eth_rx_pkg::beat_t arp_beat_o,
    output eth_rx_pkg::beat_t udp_beat_o,
    output logic              udp_ok_o
);
    import eth_rx_pkg::*;

    split_state_t state;
    count_t       byte_idx;
    hdr_verdict_t verdict;
    sum_t         pseudo_sum;
    sum_t         ip_sum_next;
    sum_t         udp_sum_next;

    split_ctrl i_split_ctrl (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .rx_beat_i  (rx_beat_i),
        .verdict_i  (verdict),
        .state_o    (state),
        .byte_idx_o (byte_idx)
    );

    header_capture i_header_capture (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .rx_beat_i     (rx_beat_i),
        .state_i       (state),
        .byte_idx_i    (byte_idx),
        .ip_sum_next_i (ip_sum_next),
        .verdict_o     (verdict),
        .pseudo_sum_o  (pseudo_sum)
    );

    inet_sum ip_sum (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .beat_i     (rx_beat_i),
        .active_i   (state == IP_HEAD),
        .sum_next_o (ip_sum_next)
    );

    inet_sum udp_sum (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .beat_i     (rx_beat_i),
        .active_i   ((state == UDP_HEAD) || (state == UDP_DATA)), // header plus payload
        .sum_next_o (udp_sum_next)
    );

    rx_output i_rx_output (
        .logic_clk      (logic_clk),
        .logic_rst      (logic_rst),
        .rx_beat_i      (rx_beat_i),
        .state_i        (state),
        .byte_idx_i     (byte_idx),
        .payload_len_i  (verdict.payload_len),
        .udp_sum_next_i (udp_sum_next),
        .pseudo_sum_i   (pseudo_sum),
        .arp_beat_o     (arp_beat_o),
        .udp_beat_o     (udp_beat_o),
        .udp_ok_o       (udp_ok_o)
    );

endmodule

// File: source/header_capture.sv
`timescale 1ns/10ps

module header_capture (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  eth_rx_pkg::beat_t        rx_beat_i,
    input  eth_rx_pkg::split_state_t state_i,
    input  eth_rx_pkg::count_t       byte_idx_i,
    input  eth_rx_pkg::sum_t         ip_sum_next_i,
    output eth_rx_pkg::hdr_verdict_t verdict_o,
    output eth_rx_pkg::sum_t         pseudo_sum_o
);
    import eth_rx_pkg::*;

    mac_t     dst_mac;
    byte_t    type_hi;
    byte_t    ver_ihl;
    byte_t    proto;
    ip_addr_t src_ip;
    ip_addr_t dst_ip;
    word_t    udp_len;
    logic     in_eth;
    word_t    eth_type;
    logic     eth_ok;
    logic     ip_ok;

    assign in_eth   = (state_i == IDLE) || (state_i == ETH_HEAD); // first byte lands in IDLE
    assign eth_type = {type_hi, rx_beat_i.data};                   // low byte still on the bus

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            dst_mac <= '0;
            type_hi <= '0;
            ver_ihl <= '0;
            proto   <= '0;
            src_ip  <= '0;
            dst_ip  <= '0;
            udp_len <= '0;
        end else if (rx_beat_i.valid) begin
            if (in_eth && (byte_idx_i < 16'd6)) begin
                dst_mac <= {dst_mac[39:0], rx_beat_i.data};
            end
            if (in_eth && (byte_idx_i == 16'd12)) begin
                type_hi <= rx_beat_i.data;
            end
            if (state_i == IP_HEAD) begin
                case (byte_idx_i)
                    16'd0:                         ver_ihl <= rx_beat_i.data;
                    16'd9:                         proto   <= rx_beat_i.data;
                    16'd12, 16'd13, 16'd14, 16'd15: src_ip <= {src_ip[23:0], rx_beat_i.data};
                    16'd16, 16'd17, 16'd18, 16'd19: dst_ip <= {dst_ip[23:0], rx_beat_i.data};
                    default: ;
                endcase
            end
            if ((state_i == UDP_HEAD) && ((byte_idx_i == 16'd4) || (byte_idx_i == 16'd5))) begin
                udp_len <= {udp_len[7:0], rx_beat_i.data};
            end
        end
    end

    assign eth_ok = (dst_mac == LOCAL_MAC) || (dst_mac == BCAST_MAC);
    assign ip_ok  = (fold_sum(ip_sum_next_i) == 16'hFFFF)
                 && ({dst_ip[23:0], rx_beat_i.data} == LOCAL_IP) // byte 19 from this beat
                 && (ver_ihl == IPV4_VER_IHL)
                 && (proto == UDP_PROTO);

    assign verdict_o = '{eth_ok:      eth_ok,
                         is_arp:      (eth_type == ARP_TYPE),
                         is_ipv4:     (eth_type == IPV4_TYPE),
                         ip_ok:       ip_ok,
                         payload_len: udp_len - UDP_HEAD_LEN};

    // pseudo header: addresses, zero/protocol word and udp length
    assign pseudo_sum_o = sum_t'(src_ip[31:16]) + sum_t'(src_ip[15:0])
                        + sum_t'(dst_ip[31:16]) + sum_t'(dst_ip[15:0])
                        + sum_t'(UDP_PROTO) + sum_t'(udp_len);

endmodule

// File: source/inet_sum.sv
`timescale 1ns/10ps

module inet_sum (
    input  logic              logic_clk,
    input  logic              logic_rst,
    input  eth_rx_pkg::beat_t beat_i,
    input  logic              active_i,
    output eth_rx_pkg::sum_t  sum_next_o
);
    import eth_rx_pkg::*;

    sum_t acc;
    logic low_phase;                    // next byte is the low half of a word
    sum_t addend;

    // a high byte is added on its own, so an odd tail already has a zero low half
    always_comb begin
        if (!beat_i.valid || !active_i) begin
            addend = '0;
        end else if (low_phase) begin
            addend = {24'h000000, beat_i.data};
        end else begin
            addend = {16'h0000, beat_i.data, 8'h00};
        end
    end

    assign sum_next_o = acc + addend;   // includes the current beat

    always_ff @(posedge logic_clk) begin
        if (logic_rst || !active_i) begin
            acc       <= '0;
            low_phase <= 1'b0;
        end else if (beat_i.valid) begin
            acc       <= sum_next_o;
            low_phase <= !low_phase;
        end
    end

endmodule

// File: source/rx_output.sv
`timescale 1ns/10ps

module rx_output (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  eth_rx_pkg::beat_t        rx_beat_i,
    input  eth_rx_pkg::split_state_t state_i,
    input  eth_rx_pkg::count_t       byte_idx_i,
    input  eth_rx_pkg::count_t       payload_len_i,
    input  eth_rx_pkg::sum_t         udp_sum_next_i,
    input  eth_rx_pkg::sum_t         pseudo_sum_i,
    output eth_rx_pkg::beat_t        arp_beat_o,
    output eth_rx_pkg::beat_t        udp_beat_o,
    output logic                     udp_ok_o
);
    import eth_rx_pkg::*;

    byte_t data_q;
    logic  arp_valid;
    logic  arp_last;
    logic  udp_valid;
    logic  udp_last;
    logic  udp_ok;
    word_t rx_csum;                     // checksum field as received
    logic  arp_beat;
    logic  udp_beat;
    logic  udp_end;
    logic  sum_good;

    assign arp_beat = rx_beat_i.valid && (state_i == ARP_DATA);
    assign udp_beat = rx_beat_i.valid && (state_i == UDP_DATA);
    assign udp_end  = (byte_idx_i == payload_len_i - 16'd1);
    assign sum_good = (fold_sum(udp_sum_next_i + pseudo_sum_i) == 16'hFFFF)
                   || (rx_csum == 16'h0000);    // zero means sender skipped it

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            arp_valid <= 1'b0;
            arp_last  <= 1'b0;
            udp_valid <= 1'b0;
            udp_last  <= 1'b0;
            udp_ok    <= 1'b0;
        end else begin
            arp_valid <= arp_beat;
            arp_last  <= arp_beat && rx_beat_i.last;
            udp_valid <= udp_beat;
            udp_last  <= udp_beat && udp_end;
            udp_ok    <= udp_beat && udp_end && sum_good;
        end
    end

    always_ff @(posedge logic_clk) begin
        data_q <= rx_beat_i.data;       // shared by both streams
        if (rx_beat_i.valid && (state_i == UDP_HEAD)
                && ((byte_idx_i == 16'd6) || (byte_idx_i == 16'd7))) begin
            rx_csum <= {rx_csum[7:0], rx_beat_i.data};
        end
    end

    assign arp_beat_o = '{data: data_q, valid: arp_valid, last: arp_last};
    assign udp_beat_o = '{data: data_q, valid: udp_valid, last: udp_last};
    assign udp_ok_o   = udp_ok;

endmodule

// File: source/split_ctrl.sv
`timescale 1ns/10ps

module split_ctrl (
    input  logic                     logic_clk,
    input  logic                     logic_rst,
    input  eth_rx_pkg::beat_t        rx_beat_i,
    input  eth_rx_pkg::hdr_verdict_t verdict_i,
    output eth_rx_pkg::split_state_t state_o,
    output eth_rx_pkg::count_t       byte_idx_o
);
    import eth_rx_pkg::*;

    split_state_t state;
    count_t       byte_idx;
    count_t       last_idx;
    logic         sec_end;

    // final index of whichever section is current
    always_comb begin
        case (state)
            ETH_HEAD: last_idx = ETH_HEAD_LEN - 16'd1;
            IP_HEAD:  last_idx = IP_HEAD_LEN - 16'd1;
            UDP_HEAD: last_idx = UDP_HEAD_LEN - 16'd1;
            default:  last_idx = verdict_i.payload_len - 16'd1; // only used in UDP_DATA
        endcase
    end

    assign sec_end = (byte_idx == last_idx);

    always_ff @(posedge logic_clk) begin
        if (logic_rst) begin
            state    <= IDLE;
            byte_idx <= '0;
        end else if (rx_beat_i.valid) begin
            byte_idx <= byte_idx + 16'd1;
            if (rx_beat_i.last) begin
                state    <= IDLE;               // end of frame, whatever the section
                byte_idx <= '0;
            end else begin
                case (state)
                    IDLE: begin
                        state <= ETH_HEAD;      // this beat was eth index 0
                    end
                    ETH_HEAD: begin
                        if (sec_end) begin
                            byte_idx <= '0;
                            if (verdict_i.eth_ok && verdict_i.is_arp) begin
                                state <= ARP_DATA;
                            end else if (verdict_i.eth_ok && verdict_i.is_ipv4) begin
                                state <= IP_HEAD;
                            end else begin
                                state <= DISCARD;
                            end
                        end
                    end
                    IP_HEAD: begin
                        if (sec_end) begin
                            byte_idx <= '0;
                            state    <= verdict_i.ip_ok ? UDP_HEAD : DISCARD;
                        end
                    end
                    UDP_HEAD: begin
                        if (sec_end) begin
                            byte_idx <= '0;
                            state    <= (verdict_i.payload_len == '0) ? DISCARD : UDP_DATA;
                        end
                    end
                    UDP_DATA: begin
                        if (sec_end) begin
                            byte_idx <= '0;
                            state    <= DISCARD;    // rest is ethernet padding
                        end
                    end
                    default: begin
                        state <= state;         // ARP_DATA and DISCARD run to last
                    end
                endcase
            end
        end
    end

    assign state_o    = state;
    assign byte_idx_o = byte_idx;

endmodule

// File: verification/frame_split_assert.sv
`timescale 1ns/10ps

module frame_split_assert (
    input logic              logic_clk,
    input logic              logic_rst,
    input eth_rx_pkg::beat_t arp_beat_o,
    input eth_rx_pkg::beat_t udp_beat_o,
    input logic              udp_ok_o
);

    // registered outputs come out of reset idle
    assert property (@(posedge logic_clk)
        logic_rst |=> (!arp_beat_o.valid && !udp_beat_o.valid && !udp_ok_o))
        else $error("output active in the cycle after reset");

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        !(arp_beat_o.valid && udp_beat_o.valid))
        else $error("arp and udp outputs valid in the same cycle");

    assert property (@(posedge logic_clk) arp_beat_o.last |-> arp_beat_o.valid)
        else $error("arp last flag without valid");

    assert property (@(posedge logic_clk) udp_beat_o.last |-> udp_beat_o.valid)
        else $error("udp last flag without valid");

endmodule

bind frame_split frame_split_assert i_frame_split_assert (
    .logic_clk  (logic_clk),
    .logic_rst  (logic_rst),
    .arp_beat_o (arp_beat_o),
    .udp_beat_o (udp_beat_o),
    .udp_ok_o   (udp_ok_o)
);

// File: verification/tb_frame_split.sv
`timescale 1ns/10ps

module tb_frame_split;
    import eth_rx_pkg::*;

    localparam int NUM_TESTS = 200;

    logic        logic_clk;
    logic        logic_rst;
    beat_t       rx_beat;
    beat_t       arp_beat;
    beat_t       udp_beat;
    logic        udp_ok;
    logic [31:0] rng_state;
    byte_t       frame[$];
    logic [8:0]  exp_arp[$];            // {last, data}
    logic [8:0]  exp_udp[$];
    logic        exp_ok[$];
    int          errors;
    int          checks;
    int          test_errors;

    frame_split i_frame_split (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .rx_beat_i  (rx_beat),
        .arp_beat_o (arp_beat),
        .udp_beat_o (udp_beat),
        .udp_ok_o   (udp_ok)
    );

    initial begin
        logic_clk = 1'b0;
        forever #5 logic_clk = ~logic_clk;
    end

    function automatic int rand_below(input int n);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return int'(rng_state[31:16]) % n;
    endfunction

    // big-endian byte pairs from the frame, folded with end-around carry
    function automatic logic [15:0] ones_sum(input int from, input int n, input logic [31:0] start);
        logic [31:0] s;
        int          i;
        s = start;
        for (i = 0; i < n; i++) begin
            s = s + ((i % 2 == 0) ? {16'h0, frame[from + i], 8'h0} : {24'h0, frame[from + i]});
        end
        while (s[31:16] != 16'h0) begin
            s = {16'h0, s[15:0]} + {16'h0, s[31:16]};
        end
        return s[15:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        test_errors++;
        $display("Error: %s", msg);
    endtask

    task automatic push_word(input logic [15:0] w);
        frame.push_back(w[15:8]);
        frame.push_back(w[7:0]);
    endtask

    // 0 arp ours, 1 arp foreign, 2-3 udp good, 4 bad payload, 5 bad udp csum,
    // 6 zero udp csum, 7 ip header reject, 8 unknown type, 9 truncated udp
    task automatic build_frame(input int kind, input int plen);
        mac_t        dst;
        logic [31:0] src_ip;
        logic [31:0] pseudo;
        logic [15:0] csum;
        logic        ok_exp;
        int          sub;
        int          i;
        frame.delete();
        dst = (rand_below(2) == 0) ? LOCAL_MAC : BCAST_MAC;
        if (kind == 1) begin
            dst = LOCAL_MAC ^ 48'h0000_0000_0100;
        end
        for (i = 0; i < 6; i++) frame.push_back(dst[47 - 8 * i -: 8]);
        for (i = 0; i < 6; i++) frame.push_back(byte_t'(rand_below(256)));
        if (kind <= 1 || kind == 8) begin
            push_word((kind == 8) ? 16'h86DD : ARP_TYPE);
            for (i = 28 + rand_below(8); i > 0; i--) frame.push_back(byte_t'(rand_below(256)));
            for (i = 14; i < frame.size() && kind == 0; i++) begin
                exp_arp.push_back({(i == frame.size() - 1), frame[i]});
            end
        end else begin
            src_ip = {16'(rand_below(65536)), 16'(rand_below(65536))};
            push_word(IPV4_TYPE);
            push_word(16'h4500);
            push_word(16'(plen + 28));
            push_word(16'(rand_below(65536)));
            push_word(16'h4000);
            push_word({8'h40, UDP_PROTO});
            push_word(16'h0000);            // ip checksum filled below
            push_word(src_ip[31:16]);
            push_word(src_ip[15:0]);
            push_word(LOCAL_IP[31:16]);
            push_word(LOCAL_IP[15:0]);
            sub = rand_below(4);
            if (kind == 7 && sub == 1) frame[33] = frame[33] ^ 8'h01;  // foreign dst ip
            if (kind == 7 && sub == 2) frame[23] = 8'h01;              // icmp
            if (kind == 7 && sub == 3) frame[14] = 8'h46;              // options present
            csum = ~ones_sum(14, 20, 32'h0);
            frame[24] = csum[15:8];
            frame[25] = csum[7:0] ^ ((kind == 7 && sub == 0) ? 8'h5a : 8'h00);
            push_word(16'(rand_below(65536)));
            push_word(16'(rand_below(65536)));
            push_word(16'(plen + 8));
            push_word(16'h0000);
            for (i = 0; i < plen; i++) frame.push_back(byte_t'(rand_below(256)));
            pseudo = {16'h0, src_ip[31:16]} + {16'h0, src_ip[15:0]} + {16'h0, LOCAL_IP[31:16]}
                   + {16'h0, LOCAL_IP[15:0]} + {24'h0, UDP_PROTO} + 32'(plen + 8);
            csum = ~ones_sum(34, plen + 8, pseudo);
            if (csum == 16'h0000 || kind == 6) begin
                csum = (kind == 6) ? 16'h0000 : 16'hFFFF;   // zero is sent as all ones
            end
            frame[40] = csum[15:8];
            frame[41] = csum[7:0] ^ ((kind == 5) ? 8'h01 : 8'h00);
            if (kind == 4) frame[42 + rand_below(plen)] ^= 8'h20;
            // only untouched checksums and a zero field are accepted
            ok_exp = (kind <= 3) || ({frame[40], frame[41]} == 16'h0000);
            for (i = rand_below(7); i > 0; i--) frame.push_back(byte_t'(rand_below(256)));
            if (kind == 9) begin
                while (frame.size() > 1 + rand_below(41)) void'(frame.pop_back());
            end else if (kind != 7 && plen > 0) begin
                for (i = 0; i < plen; i++) exp_udp.push_back({(i == plen - 1), frame[42 + i]});
                exp_ok.push_back(ok_exp);
            end
        end
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < frame.size(); i++) begin
            if (rand_below(8) == 0) begin
                repeat (1 + rand_below(2)) begin
                    @(posedge logic_clk);
                    rx_beat <= '0;          // idle gap
                end
            end
            @(posedge logic_clk);
            rx_beat <= '{data: frame[i], valid: 1'b1, last: (i == frame.size() - 1)};
        end
    endtask

    task automatic wait_drain();
        int guard;
        guard = 0;
        repeat (2) @(posedge logic_clk);
        while ((exp_arp.size() + exp_udp.size() + exp_ok.size()) != 0 && guard < 16) begin
            @(posedge logic_clk);
            guard++;
        end
        if ((exp_arp.size() + exp_udp.size() + exp_ok.size()) != 0) begin
            report_error("expected output bytes never appeared");
            exp_arp.delete();
            exp_udp.delete();
            exp_ok.delete();
        end
    endtask

    // each output beat against the front of its queue
    always @(posedge logic_clk) begin : output_monitor
        logic [8:0] want;
        logic       want_ok;
        if (!logic_rst && arp_beat.valid) begin
            if (exp_arp.size() == 0) begin
                report_error("ARP byte appeared with no ARP byte expected");
            end else begin
                want = exp_arp.pop_front();
                check_value("arp_beat_o.data", 32'(arp_beat.data), 32'(want[7:0]));
                check_value("arp_beat_o.last", 32'(arp_beat.last), 32'(want[8]));
            end
        end
        if (!logic_rst && udp_beat.valid) begin
            if (exp_udp.size() == 0) begin
                report_error("UDP byte appeared with no UDP byte expected");
            end else begin
                want = exp_udp.pop_front();
                check_value("udp_beat_o.data", 32'(udp_beat.data), 32'(want[7:0]));
                check_value("udp_beat_o.last", 32'(udp_beat.last), 32'(want[8]));
                if (want[8] && exp_ok.size() != 0) begin
                    want_ok = exp_ok.pop_front();
                    check_value("udp_ok_o", 32'(udp_ok), 32'(want_ok));
                end
            end
        end
    end

    // budget covers the longest frames with gaps plus reset and drain time
    initial begin : watchdog
        repeat (NUM_TESTS * 120 + 200) @(posedge logic_clk);
        $display("Timeout: the tests did not finish within the cycle budget");
        $display("Errors found");
        $finish;
    end

    initial begin : main
        int kind;
        int plen;
        int t;
        rng_state = 32'h657a_26cb;
        errors    = 0;
        checks    = 0;
        logic_rst <= 1'b1;
        rx_beat   <= '0;
        repeat (5) @(posedge logic_clk);
        logic_rst <= 1'b0;
        for (t = 0; t < NUM_TESTS; t++) begin
            test_errors = 0;
            kind = rand_below(10);
            plen = rand_below(41);
            if (kind == 4 && plen == 0) plen = 1;
            build_frame(kind, plen);
            send_frame();
            if (kind == 9) begin
                build_frame(2, plen);       // starts right after the cut frame
                send_frame();
            end
            @(posedge logic_clk);
            rx_beat <= '0;
            wait_drain();
            $display("test %0d kind %0d payload %0d: %s", t, kind, plen,
                     (test_errors == 0) ? "pass" : "fail");
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
